/* hdl/bin_to_bcd.sv */
// Free-running double-dabble converter, binary display value to 4 BCD digits
// One capture cycle plus BIN_W shift cycles per pass, output updated per pass

module bin_to_bcd (
    input  logic               clk,
    input  logic               rst,
    input  calc_pkg::product_t bin,
    output calc_pkg::bcd_t     bcd
);
    import calc_pkg::*;

    logic [BCD_STEP_W-1:0] step;  // 0 is capture, then shift steps
    dabble_t               sr;    // BCD digits above the binary bits
    dabble_t               sr_next;

    // Add 3 to every digit of 5 or more, then shift left one bit
    function automatic dabble_t dabble_step(dabble_t cur);
        dabble_t t;
        t = cur;
        for (int j = 0; j < BCD_W / 4; j++) begin
            if (t[BIN_W + 4*j +: 4] >= 4'd5)
                t[BIN_W + 4*j +: 4] = t[BIN_W + 4*j +: 4] + 4'd3;
        end
        return t << 1;
    endfunction

    assign sr_next = dabble_step(sr);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            step <= '0;
            bcd  <= '0;
        end else if (step == BCD_STEP_W'(BIN_W)) begin
            bcd  <= sr_next[BCD_W+BIN_W-1 -: BCD_W];  // Last shift, publish
            step <= '0;
        end else begin
            step <= step + 1'b1;
        end
    end

    // Shift register
    always_ff @(posedge clk) begin
        if (step == '0)
            sr <= {{BCD_W{1'b0}}, bin};  // Capture a new value
        else
            sr <= sr_next;
    end

endmodule

/* hdl/calc_pkg.sv */
// Shared types, key codes and timing constants for the keypad calculator
// Imported by every RTL block of the design

package calc_pkg;

    // ************************************************************************
    // Widths and timing
    // ************************************************************************
    localparam int BIN_W          = 14;   // Binary product width, 99*99 fits
    localparam int BCD_W          = 16;   // Four BCD digits
    localparam int SCAN_DIV       = 8;    // Clocks per keypad row
    localparam int DEBOUNCE_SCANS = 3;    // Stable full scans before a key counts
    localparam int DIGIT_DIV      = 16;   // Clocks per displayed digit

    localparam int SCAN_CNT_W  = $clog2(SCAN_DIV);
    localparam int DEB_CNT_W   = $clog2(DEBOUNCE_SCANS + 1);
    localparam int DIGIT_CNT_W = $clog2(DIGIT_DIV);
    localparam int BCD_STEP_W  = $clog2(BIN_W + 1);  // Capture step plus BIN_W shifts

    // ************************************************************************
    // Plain vector types
    // ************************************************************************
    typedef logic [3:0]             row_t;       // One-hot row drive, active high
    typedef logic [3:0]             col_t;       // Column inputs, active high
    typedef logic [3:0]             key_code_t;  // 0-9 digits, A-F as 10-15
    typedef logic [6:0]             operand_t;   // 0 to 99
    typedef logic [BIN_W-1:0]       product_t;   // Up to 9801
    typedef logic [BCD_W-1:0]       bcd_t;       // Units in low nibble
    typedef logic [BCD_W+BIN_W-1:0] dabble_t;    // Double-dabble shift register
    typedef logic [6:0]             seg_t;       // g..a, active low
    typedef logic [3:0]             anode_t;     // Digit enables, active low

    // Operator keys
    localparam key_code_t KEY_MUL = 4'd11;  // B
    localparam key_code_t KEY_EQ  = 4'd12;  // C

    // ************************************************************************
    // Structs and enums
    // ************************************************************************
    typedef struct packed {
        logic      valid;  // One cycle per accepted press
        key_code_t code;
    } key_event_t;

    typedef struct packed {
        logic     start;   // One-cycle request
        operand_t a;
        operand_t b;
    } mul_req_t;

    typedef enum logic [1:0] {
        ENTER_A,
        ENTER_B,
        BUSY,
        SHOW
    } entry_state_t;

endpackage

/* hdl/keypad_calc_top.sv */
// Top level of the keypad multiplier calculator
// Keypad scan, operand entry, multiply, BCD convert and display

module keypad_calc_top (
    input  logic             clk,
    input  logic             rst,
    input  calc_pkg::col_t   col,
    output calc_pkg::row_t   row,
    output calc_pkg::seg_t   seg,
    output calc_pkg::anode_t anode
);
    import calc_pkg::*;

    key_event_t key;         // Debounced press
    mul_req_t   mul_req;     // Start and operands
    product_t   product;
    logic       mul_done;
    product_t   disp_value;  // Operand or product being shown
    bcd_t       disp_bcd;

    keypad_scanner scanner_i (
        .clk (clk),
        .rst (rst),
        .col (col),
        .row (row),
        .key (key)
    );

    operand_entry entry_i (
        .clk        (clk),
        .rst        (rst),
        .key        (key),
        .done       (mul_done),
        .product    (product),
        .req        (mul_req),
        .disp_value (disp_value)
    );

    repeated_add_multiplier mult_i (
        .clk     (clk),
        .rst     (rst),
        .req     (mul_req),
        .product (product),
        .done    (mul_done)
    );

    bin_to_bcd bcd_i (
        .clk (clk),
        .rst (rst),
        .bin (disp_value),
        .bcd (disp_bcd)
    );

    seg_display_mux disp_i (
        .clk   (clk),
        .rst   (rst),
        .bcd   (disp_bcd),
        .seg   (seg),
        .anode (anode)
    );

endmodule

/* hdl/keypad_scanner.sv */
// Scans a 4x4 matrix keypad row by row and debounces the result
// Emits a single key event per physical press

module keypad_scanner (
    input  logic                 clk,
    input  logic                 rst,
    input  calc_pkg::col_t       col,
    output calc_pkg::row_t       row,
    output calc_pkg::key_event_t key
);
    import calc_pkg::*;

    logic [SCAN_CNT_W-1:0] scan_cnt;   // Clocks within the current row
    logic                  scan_tick;  // Last clock of a row
    logic                  scan_end;   // Last clock of row 3
    logic                  hit;        // Key already seen this scan
    key_code_t             hit_code;
    key_code_t             cur_code;   // Key under the current row
    logic                  res_valid;  // Scan result, valid at scan_end
    key_code_t             res_code;
    key_code_t             last_code;  // Previous scan result
    logic [DEB_CNT_W-1:0]  stable_cnt; // Consecutive scans with same key
    logic [DEB_CNT_W-1:0]  cnt_next;
    logic                  released;   // A none scan since the last event
    logic                  fire;

    // Row/column position to key code, reference layout
    function automatic key_code_t decode_key(row_t r, col_t c);
        logic [1:0] ri;
        logic [1:0] ci;
        ri = 2'd0;
        if (r[1]) ri = 2'd1;
        if (r[2]) ri = 2'd2;
        if (r[3]) ri = 2'd3;
        ci = 2'd3;                  // Lowest active column wins
        if (c[2]) ci = 2'd2;
        if (c[1]) ci = 2'd1;
        if (c[0]) ci = 2'd0;
        case ({ri, ci})
            4'h0: return 4'd1;
            4'h1: return 4'd2;
            4'h2: return 4'd3;
            4'h3: return 4'd10;     // A
            4'h4: return 4'd4;
            4'h5: return 4'd5;
            4'h6: return 4'd6;
            4'h7: return KEY_MUL;   // B
            4'h8: return 4'd7;
            4'h9: return 4'd8;
            4'hA: return 4'd9;
            4'hB: return KEY_EQ;    // C
            4'hC: return 4'd14;     // E
            4'hD: return 4'd0;
            4'hE: return 4'd15;     // F
            default: return 4'd13;  // D
        endcase
    endfunction

    assign scan_tick = (scan_cnt == SCAN_CNT_W'(SCAN_DIV - 1));
    assign scan_end  = scan_tick && row[3];
    assign cur_code  = decode_key(row, col);

    // Earlier row beats the current sample
    assign res_valid = hit || (|col);
    assign res_code  = hit ? hit_code : cur_code;

    // Stability count, saturating at the threshold
    always_comb begin
        if (!res_valid) begin
            cnt_next = '0;
        end else if (stable_cnt != '0 && res_code == last_code) begin
            if (stable_cnt == DEB_CNT_W'(DEBOUNCE_SCANS))
                cnt_next = stable_cnt;
            else
                cnt_next = stable_cnt + 1'b1;
        end else begin
            cnt_next = DEB_CNT_W'(1);  // New key starts counting
        end
    end

    assign fire = scan_end && released && (cnt_next == DEB_CNT_W'(DEBOUNCE_SCANS));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            scan_cnt   <= '0;
            row        <= 4'b0001;
            hit        <= 1'b0;
            hit_code   <= '0;
            last_code  <= '0;
            stable_cnt <= '0;
            released   <= 1'b1;
            key        <= '0;
        end else begin
            scan_cnt  <= scan_tick ? '0 : scan_cnt + 1'b1;
            key.valid <= fire;
            key.code  <= res_code;
            if (scan_tick) begin
                row <= {row[2:0], row[3]};  // Ring counter, row 0 first
                if (scan_end) begin
                    hit        <= 1'b0;
                    stable_cnt <= cnt_next;
                    last_code  <= res_code;
                    if (!res_valid)
                        released <= 1'b1;
                    else if (fire)
                        released <= 1'b0;
                end else if (!hit && (|col)) begin
                    hit      <= 1'b1;
                    hit_code <= cur_code;
                end
            end
        end
    end

endmodule

/* hdl/operand_entry.sv */
// Entry FSM that builds the two decimal operands from key events
// Requests the product on equals and picks the value for the display

module operand_entry (
    input  logic                 clk,
    input  logic                 rst,
    input  calc_pkg::key_event_t key,
    input  logic                 done,
    input  calc_pkg::product_t   product,
    output calc_pkg::mul_req_t   req,
    output calc_pkg::product_t   disp_value
);
    import calc_pkg::*;

    entry_state_t state;
    operand_t     a;
    operand_t     b;
    logic         start;
    logic         digit_key;  // Event carrying 0-9
    logic         mul_key;
    logic         eq_key;

    // Shift in a decimal digit, keeping the last two typed
    function automatic operand_t append_digit(operand_t cur, key_code_t d);
        return operand_t'((cur % 10) * 10 + d);
    endfunction

    assign digit_key = key.valid && (key.code <= 4'd9);
    assign mul_key   = key.valid && (key.code == KEY_MUL);
    assign eq_key    = key.valid && (key.code == KEY_EQ);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= ENTER_A;
            a     <= '0;
            b     <= '0;
            start <= 1'b0;
        end else begin
            start <= 1'b0;  // Single-cycle request
            case (state)
                ENTER_A: begin
                    if (digit_key) begin
                        a <= append_digit(a, key.code);
                    end else if (mul_key) begin
                        b     <= '0;
                        state <= ENTER_B;
                    end
                end
                ENTER_B: begin
                    if (digit_key) begin
                        b <= append_digit(b, key.code);
                    end else if (eq_key) begin
                        start <= 1'b1;
                        state <= BUSY;
                    end
                end
                BUSY: begin
                    if (done)
                        state <= SHOW;  // Keys ignored while multiplying
                end
                SHOW: begin
                    if (digit_key) begin
                        a     <= operand_t'(key.code);  // Fresh first operand
                        state <= ENTER_A;
                    end
                end
                default: state <= ENTER_A;
            endcase
        end
    end

    always_comb begin
        req.start = start;
        req.a     = a;
        req.b     = b;
    end

    // Multiplier output holds the last product until the next done
    always_comb begin
        case (state)
            ENTER_A: disp_value = product_t'(a);
            ENTER_B: disp_value = product_t'(b);
            default: disp_value = product;
        endcase
    end

endmodule

/* hdl/repeated_add_multiplier.sv */
// Multiplies two operands by adding a into an accumulator b times
// Start is taken only when idle, done pulses with the product

module repeated_add_multiplier (
    input  logic               clk,
    input  logic               rst,
    input  calc_pkg::mul_req_t req,
    output calc_pkg::product_t product,
    output logic               done
);
    import calc_pkg::*;

    logic     busy;
    logic     accept;   // Start while idle
    logic     running;  // Still adding
    product_t acc;
    operand_t cnt;      // Additions done so far
    operand_t mcand;
    operand_t mplier;

    assign accept  = req.start && !busy;
    assign running = (cnt < mplier);

    // Control and result
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            product <= '0;
        end else begin
            done <= 1'b0;
            if (accept) begin
                busy <= 1'b1;
            end else if (busy && !running) begin
                product <= acc;   // b additions complete
                done    <= 1'b1;
                busy    <= 1'b0;
            end
        end
    end

    // Datapath
    always_ff @(posedge clk) begin
        if (accept) begin
            acc    <= '0;
            cnt    <= '0;
            mcand  <= req.a;
            mplier <= req.b;
        end else if (busy && running) begin
            acc <= acc + product_t'(mcand);
            cnt <= cnt + 1'b1;
        end
    end

endmodule

/* hdl/seg_display_mux.sv */
// Time-multiplexed four-digit seven-segment driver
// Units digit first, anodes and segments both active low

module seg_display_mux (
    input  logic           clk,
    input  logic           rst,
    input  calc_pkg::bcd_t bcd,
    output calc_pkg::seg_t seg,
    output calc_pkg::anode_t anode
);
    import calc_pkg::*;

    logic [DIGIT_CNT_W-1:0] div_cnt;  // Clocks in the current digit
    logic                   digit_tick;
    logic [1:0]             digit_idx; // 0 units .. 3 thousands
    logic [3:0]             nibble;

    // BCD to segments g..a, anything above 9 blanks
    function automatic seg_t decode_seg(logic [3:0] d);
        case (d)
            4'd0:    return 7'b1000000;
            4'd1:    return 7'b1111001;
            4'd2:    return 7'b0100100;
            4'd3:    return 7'b0110000;
            4'd4:    return 7'b0011001;
            4'd5:    return 7'b0010010;
            4'd6:    return 7'b0000010;
            4'd7:    return 7'b1111000;
            4'd8:    return 7'b0000000;
            4'd9:    return 7'b0011000;
            default: return 7'b1111111;
        endcase
    endfunction

    assign digit_tick = (div_cnt == DIGIT_CNT_W'(DIGIT_DIV - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            div_cnt   <= '0;
            digit_idx <= 2'd0;
        end else begin
            div_cnt <= digit_tick ? '0 : div_cnt + 1'b1;
            if (digit_tick)
                digit_idx <= digit_idx + 2'd1;  // Wraps after thousands
        end
    end

    assign nibble = bcd[4*digit_idx +: 4];
    assign seg    = decode_seg(nibble);
    assign anode  = ~(anode_t'(1) << digit_idx);

endmodule

/* sim.f */
hdl/calc_pkg.sv
hdl/keypad_scanner.sv
hdl/operand_entry.sv
hdl/repeated_add_multiplier.sv
hdl/bin_to_bcd.sv
hdl/seg_display_mux.sv
hdl/keypad_calc_top.sv
tb/keypad_model.sv
tb/keypad_calc_tb.sv

/* tb/keypad_calc_tb.sv */
// Testbench for the keypad multiplier calculator
// Presses keys through a keypad model and reads the multiplexed display back

module keypad_calc_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import calc_pkg::*;

    // ************************************************************************
    // Press timing and run limit
    // ************************************************************************
    localparam int SCAN_CLKS     = 4 * SCAN_DIV;  // One full keypad scan
    localparam int HOLD_CLKS     = 6 * SCAN_CLKS;
    localparam int RELEASE_CLKS  = 6 * SCAN_CLKS;
    localparam int PRESS_CLKS    = HOLD_CLKS + RELEASE_CLKS + 40;
    localparam int REFRESH_CLKS  = 4 * DIGIT_DIV;  // All four digits once
    localparam int PRESS_BUDGET  = 72;             // Presses in the whole sequence
    localparam int WATCHDOG_CLKS = PRESS_BUDGET * PRESS_CLKS * 5 / 4 + 20 * REFRESH_CLKS;

    logic        clk;
    logic        rst;
    logic        held;        // Keypad model contact
    key_code_t   held_code;
    col_t        col;
    row_t        row;
    seg_t        seg;
    anode_t      anode;

    bcd_t        shown;       // Digits read back from the display
    anode_t      prev_anode;
    row_t        prev_row;
    key_code_t   key_log[$];  // Every key pressed since reset
    logic [15:0] lfsr;
    int          errors;
    int          checks;
    int          tests_run;
    int          tests_failed;
    int          test_errors; // Error count when the current test began
    operand_t    op_a;
    operand_t    op_b;

    keypad_calc_top dut_i (
        .clk   (clk),
        .rst   (rst),
        .col   (col),
        .row   (row),
        .seg   (seg),
        .anode (anode)
    );

    keypad_model keypad_i (
        .row       (row),
        .held      (held),
        .held_code (held_code),
        .col       (col)
    );

    always #20 clk = ~clk;  // 40 ns period

    // ************************************************************************
    // Reference model and helpers
    // ************************************************************************

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [15:0] draw_bits(int n);
        logic [15:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r    = {r[14:0], fb};
        end
        return r;
    endfunction

    // Replays the key log through the entry rules
    function automatic product_t expected_display();
        int st;  // 0 first operand, 1 second operand, 2 result
        int a;
        int b;
        int p;
        int k;
        st = 0;
        a  = 0;
        b  = 0;
        p  = 0;
        foreach (key_log[i]) begin
            k = key_log[i];
            case (st)
                0: begin
                    if (k <= 9) a = (a * 10 + k) % 100;  // Last two digits kept
                    else if (k == KEY_MUL) begin
                        b  = 0;
                        st = 1;
                    end
                end
                1: begin
                    if (k <= 9) b = (b * 10 + k) % 100;
                    else if (k == KEY_EQ) begin
                        p  = a * b;
                        st = 2;
                    end
                end
                default: begin
                    if (k <= 9) begin
                        a  = k;  // Fresh first operand
                        st = 0;
                    end
                end
            endcase
        end
        return product_t'((st == 0) ? a : (st == 1) ? b : p);
    endfunction

    // Binary value to four decimal digits with units low
    function automatic bcd_t to_digits(product_t v);
        bcd_t r;
        int   n;
        n = v;
        for (int i = 0; i < 4; i++) begin
            r[4*i +: 4] = 4'(n % 10);
            n = n / 10;
        end
        return r;
    endfunction

    // Segment pattern g..a back to a digit or F when blank or garbage
    function automatic logic [3:0] seg_to_digit(seg_t s);
        case (s)
            7'b1000000: return 4'd0;
            7'b1111001: return 4'd1;
            7'b0100100: return 4'd2;
            7'b0110000: return 4'd3;
            7'b0011001: return 4'd4;
            7'b0010010: return 4'd5;
            7'b0000010: return 4'd6;
            7'b1111000: return 4'd7;
            7'b0000000: return 4'd8;
            7'b0011000: return 4'd9;
            default:    return 4'hF;
        endcase
    endfunction

    task automatic check_bcd(bcd_t got, bcd_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s reads %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_anode(anode_t got, anode_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_row(row_t got, row_t exp, string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // ************************************************************************
    // Display sampler and keypad row monitor
    // ************************************************************************
    always @(negedge clk) begin
        if (rst) begin
            prev_anode <= 4'b0111;  // Next phase after this is units
            prev_row   <= 4'b1000;  // Row 0 comes next
        end else begin
            if (anode !== prev_anode)
                check_anode(anode, {prev_anode[2:0], prev_anode[3]}, "anode step");
            if (row !== prev_row)
                check_row(row, {prev_row[2:0], prev_row[3]}, "row step");
            prev_anode <= anode;
            prev_row   <= row;
            case (anode)
                4'b1110: shown[3:0]   <= seg_to_digit(seg);
                4'b1101: shown[7:4]   <= seg_to_digit(seg);
                4'b1011: shown[11:8]  <= seg_to_digit(seg);
                4'b0111: shown[15:12] <= seg_to_digit(seg);
                default: ;  // Flagged by the step check
            endcase
        end
    end

    // Hold, release, settle, then compare with the replayed key log
    task automatic press_key(key_code_t code);
        @(posedge clk);
        held      <= 1'b1;
        held_code <= code;
        repeat (HOLD_CLKS) @(posedge clk);
        held <= 1'b0;
        repeat (RELEASE_CLKS + 40) @(posedge clk);
        key_log.push_back(code);
        check_bcd(shown, to_digits(expected_display()),
                  $sformatf("display after key %h", code));
    endtask

    task automatic enter_operand(operand_t v);
        if (v >= 10)
            press_key(key_code_t'(v / 10));  // Tens first
        press_key(key_code_t'(v % 10));
    endtask

    // Keys with no function in this design
    task automatic press_unused_keys();
        press_key(4'd10);
        press_key(4'd13);
        press_key(4'd14);
        press_key(4'd15);
    endtask

    task automatic begin_test();
        test_errors = errors;
    endtask

    task automatic end_test(string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d  %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d  %s: %0d errors", tests_run, name, errors - test_errors);
        end
    endtask

    // ************************************************************************
    // Test sequence
    // ************************************************************************
    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        held         = 1'b0;
        held_code    = '0;
        shown        = '1;
        lfsr         = 16'd34031;
        errors       = 0;
        checks       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;

        begin_test();
        @(negedge clk);
        check_anode(anode, 4'b1110, "anode after reset");
        check_row(row, 4'b0001, "row after reset");
        repeat (4 * REFRESH_CLKS) @(posedge clk);  // Several full refreshes
        check_bcd(shown, 16'h0000, "display after reset");
        end_test("reset state with anode and row rotation");

        begin_test();
        press_key(4'd4);
        press_key(4'd7);
        press_key(4'd3);  // 473 keeps 73
        end_test("three digits keep the last two");

        begin_test();
        press_key(KEY_MUL);  // Second operand starts at 0
        press_key(4'd5);
        press_key(4'd8);
        press_key(KEY_EQ);
        check_bcd(shown, 16'h4234, "product 73 x 58");
        end_test("second operand entry");

        begin_test();
        for (int i = 0; i < 8; i++) begin
            op_a = operand_t'(draw_bits(7) % 100);
            op_b = operand_t'(draw_bits(7) % 100);
            if (i == 2)
                op_a = '0;
            if (i == 5)
                op_b = '0;
            if (i == 7) begin
                op_a = 7'd99;
                op_b = 7'd99;
            end
            enter_operand(op_a);
            press_key(KEY_MUL);
            enter_operand(op_b);
            press_key(KEY_EQ);
            check_bcd(shown, to_digits(product_t'(int'(op_a) * int'(op_b))),
                      $sformatf("product %0d x %0d", op_a, op_b));
        end
        end_test("LFSR operand products");

        begin_test();
        press_unused_keys();  // In the result state
        press_key(4'd5);
        press_unused_keys();  // First operand
        press_key(KEY_MUL);
        press_key(4'd2);
        press_unused_keys();  // Second operand
        press_key(KEY_EQ);
        end_test("unused keys ignored");

        begin_test();
        press_key(4'd7);
        check_bcd(shown, 16'h0007, "new first operand");
        end_test("digit after result");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // Watchdog sized from the press count
    initial begin
        repeat (WATCHDOG_CLKS) @(posedge clk);
        $display("Watchdog expired after %0d clocks, the sequence did not finish",
                 WATCHDOG_CLKS);
        $display("Test failures found");
        $finish;
    end

endmodule

/* tb/keypad_model.sv */
// Behavioural 4x4 matrix keypad for the calculator testbench
// While held is set, raises the column of held_code when its row is driven

module keypad_model (
    input  calc_pkg::row_t      row,
    input  logic                held,
    input  calc_pkg::key_code_t held_code,
    output calc_pkg::col_t      col
);
    timeunit 1ns;
    timeprecision 1ps;
    import calc_pkg::*;

    logic [1:0] key_row;  // Matrix position of the held key
    logic [1:0] key_col;

    // Key code to row and column, same layout as the board
    always_comb begin
        case (held_code)
            4'd1:    {key_row, key_col} = 4'h0;
            4'd2:    {key_row, key_col} = 4'h1;
            4'd3:    {key_row, key_col} = 4'h2;
            4'd10:   {key_row, key_col} = 4'h3;  // A
            4'd4:    {key_row, key_col} = 4'h4;
            4'd5:    {key_row, key_col} = 4'h5;
            4'd6:    {key_row, key_col} = 4'h6;
            4'd11:   {key_row, key_col} = 4'h7;  // B
            4'd7:    {key_row, key_col} = 4'h8;
            4'd8:    {key_row, key_col} = 4'h9;
            4'd9:    {key_row, key_col} = 4'hA;
            4'd12:   {key_row, key_col} = 4'hB;  // C
            4'd14:   {key_row, key_col} = 4'hC;  // E
            4'd0:    {key_row, key_col} = 4'hD;
            4'd15:   {key_row, key_col} = 4'hE;  // F
            default: {key_row, key_col} = 4'hF;  // D
        endcase
    end

    // Contact closes only while its row is driven
    assign col = (held && row[key_row]) ? col_t'(4'b0001 << key_col) : '0;

endmodule
